//--- ht_input_port.f
+incdir+include
logic/ht_router_pkg.sv
logic/ht_route_decode.sv
logic/ht_vc_lane.sv
logic/ht_output_alloc.sv
logic/ht_input_port.sv
sim/ht_clk_gen.sv
sim/tb_ht_input_port.sv

//--- Bender.yml
package:
  name: ht_input_port

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/ht_router_pkg.sv
      - logic/ht_route_decode.sv
      - logic/ht_vc_lane.sv
      - logic/ht_output_alloc.sv
      - logic/ht_input_port.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/ht_clk_gen.sv
      - sim/tb_ht_input_port.sv

//--- sim/tb_ht_input_port.sv
`timescale 1ns/1ps

`include "ht_router_params.svh"

module tb_ht_input_port
  import ht_router_pkg::*;
();

  localparam int RING = `HT_NUM_TILES_X;
  localparam int BASE = `HT_BASE_X_CORD;
  localparam ht_dir_e TB_FROM = W;
  localparam int MAX_CYCLES = (100 + 200 + 80 + 120) * 20 + 200;

  logic                            clk;
  logic                            arst_n;
  logic [`HT_X_CORD_WIDTH-1:0]     my_x;
  logic [`HT_Y_CORD_WIDTH-1:0]     my_y;
  ht_flit_t [1:0]                  in_flit;
  logic [1:0]                      in_valid;
  logic [1:0]                      in_ready;
  ht_flit_t [HT_NUM_VC_OUT-1:0]    out_flit;
  logic [HT_NUM_VC_OUT-1:0]        out_valid;
  logic [HT_NUM_VC_OUT-1:0]        out_ready;

  // expected flits per lane and slot, and each lane's slot order
  ht_flit_t   exp_q [2][HT_NUM_VC_OUT][$];
  ht_vc_out_e order_q [2][$];
  int          occ [2];
  // lane that lost a contested transfer on a slot, -1 when none
  int          owed [HT_NUM_VC_OUT];
  int          head_slot [2];
  logic [14:0] seq [2];
  logic        rand_ready;
  int          test_errs;
  int          tests_ok;
  int          tests_bad;
  int          cycles;

  ht_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  ht_input_port #(.FROM_DIR(TB_FROM)) dut0 (
    .clk_i(clk), .arst_n_i(arst_n), .my_x_i(my_x), .my_y_i(my_y),
    .in_flit_i(in_flit), .in_valid_i(in_valid), .in_ready_o(in_ready),
    .out_flit_o(out_flit), .out_valid_o(out_valid), .out_ready_i(out_ready)
  );

  function automatic int ring_of(input int col);
    if (col % 2 == 1) return RING - 1 - (col - BASE) / 2;
    return (col - BASE) / 2;
  endfunction

  function automatic int col_of_ring(input int r);
    if (r < RING / 2) return BASE + 2 * r;
    return BASE + 2 * (RING - 1 - r) + 1;
  endfunction

  // folded torus routing model
  function automatic ht_vc_out_e predict_slot(input ht_flit_t f, input int mx, input int my,
                                              input int vc);
    int  mr;
    int  cw;
    int  ccw;
    int  vc_out;
    bit  vert;
    bit  cw_way;
    bit  east;
    if (f.dest_x == mx && f.dest_y == my) return VC_P;
    vert = (`HT_XY_ORDER != 0) ? (f.dest_x == mx) : (f.dest_y != my);
    if (vert) return (int'(f.dest_y) > my) ? VC_S : VC_N;
    mr = ring_of(mx);
    cw = (ring_of(f.dest_x) - mr + RING) % RING;
    ccw = (RING - cw) % RING;
    cw_way = (cw == ccw) ? (mr % 2 == 0) : (cw < ccw);
    east = (mx % 2 == 0) ? cw_way : !cw_way;
    vc_out = vc;
    if (mx % 2 == 0) begin
      if (TB_FROM == P) vc_out = 0;
      else if (east && mx - BASE == RING / 2 - 2) vc_out = 1;
      else if (!east && mx - BASE == RING / 2) vc_out = 1;
    end
    if (east) return (vc_out == 1) ? VC_E1 : VC_E0;
    return (vc_out == 1) ? VC_W1 : VC_W0;
  endfunction

  task automatic note_failure(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic check_flit(input string name, input ht_flit_t exp, input ht_flit_t act);
    if (exp !== act) begin
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_vc_out(input string name, input ht_vc_out_e exp, input ht_vc_out_e act);
    if (exp !== act) begin
      $display("ERROR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
      test_errs++;
    end
  endtask

  // the loser of a contested transfer must get the slot next
  task automatic check_turn(input int s, input int l);
    if (owed[s] >= 0 && owed[s] != l) begin
      note_failure($sformatf("slot %0d served lane %0d while lane %0d was owed its turn",
                             s, l, owed[s]));
    end
    owed[s] = (head_slot[1 - l] == s) ? 1 - l : -1;
  endtask

  task automatic take_output(input int s, input ht_flit_t f);
    int l;
    l = f.payload[15];
    occ[l]--;
    if (order_q[l].size() == 0) begin
      note_failure($sformatf("slot %0d sent a lane %0d flit that nobody expected", s, l));
      return;
    end
    check_vc_out($sformatf("out slot of lane %0d", l), order_q[l].pop_front(), ht_vc_out_e'(s));
    if (exp_q[l][s].size() == 0) begin
      note_failure($sformatf("slot %0d sent a lane %0d flit with its queue empty", s, l));
    end else begin
      check_flit($sformatf("out_flit_o[%0d]", s), exp_q[l][s].pop_front(), f);
    end
  endtask

  task automatic take_input(input int l, input ht_flit_t f);
    ht_vc_out_e slot;
    slot = predict_slot(f, my_x, my_y, l);
    occ[l]++;
    order_q[l].push_back(slot);
    exp_q[l][slot].push_back(f);
  endtask

  // transfers complete at the next rising edge, so sample mid cycle
  always @(negedge clk) begin
    if (arst_n) begin
      for (int l = 0; l < 2; l++) begin
        check_bit($sformatf("in_ready_o[%0d]", l), occ[l] != `HT_FIFO_DEPTH, in_ready[l]);
        head_slot[l] = (order_q[l].size() != 0) ? int'(order_q[l][0]) : -1;
      end
      for (int s = 0; s < HT_NUM_VC_OUT; s++) begin
        if (out_valid[s] && out_ready[s]) begin
          check_turn(s, out_flit[s].payload[15]);
          take_output(s, out_flit[s]);
        end
      end
      for (int l = 0; l < 2; l++) begin
        if (in_valid[l] && in_ready[l]) take_input(l, in_flit[l]);
      end
    end
  end

  always @(posedge clk) begin
    #2;
    out_ready = rand_ready ? HT_NUM_VC_OUT'($urandom) : '1;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, flits still in flight", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  function automatic ht_flit_t pick_dest(input int kind);
    ht_flit_t f;
    f = '0;
    f.dest_x = `HT_X_CORD_WIDTH'(BASE + $urandom_range(0, RING - 1));
    f.dest_y = `HT_Y_CORD_WIDTH'($urandom_range(0, 7));
    if (kind == 2) begin
      f.dest_x = my_x;
    end else if (kind == 3 || kind == 4) begin
      f.dest_y = my_y;
      // opposite column so both ways round are equally long
      if (kind == 3 && $urandom_range(0, 3) == 0) begin
        f.dest_x = `HT_X_CORD_WIDTH'(col_of_ring((ring_of(my_x) + RING / 2) % RING));
      end
    end else begin
      f.dest_x = my_x;
      f.dest_y = $urandom_range(0, 1) ? my_y : my_y + 1'b1;
    end
    return f;
  endfunction

  task automatic send_lane(input int lane, input int n, input int kind);
    ht_flit_t f;
    int       gap;
    for (int i = 0; i < n; i++) begin
      f = pick_dest(kind);
      f.payload = {lane[0], seq[lane]};
      seq[lane] = seq[lane] + 1'b1;
      in_flit[lane] = f;
      in_valid[lane] = 1'b1;
      @(negedge clk);
      while (!in_ready[lane]) @(negedge clk);
      @(posedge clk);
      #2;
      in_valid[lane] = 1'b0;
      gap = (kind == 5) ? ($urandom_range(0, 3) == 0) : $urandom_range(0, 3);
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic run_lanes(input int kind, input int n0, input int n1);
    fork
      send_lane(0, n0, kind);
      send_lane(1, n1, kind);
    join
    while (occ[0] != 0 || occ[1] != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic set_tile(input int x, input int y);
    my_x = `HT_X_CORD_WIDTH'(x);
    my_y = `HT_Y_CORD_WIDTH'(y);
  endtask

  task automatic finish_test(input int num, input string name);
    for (int l = 0; l < 2; l++) begin
      for (int s = 0; s < HT_NUM_VC_OUT; s++) begin
        if (exp_q[l][s].size() != 0) begin
          note_failure($sformatf("%0d flits of lane %0d for slot %0d never left the port",
                                 exp_q[l][s].size(), l, s));
          exp_q[l][s].delete();
        end
      end
      order_q[l].delete();
    end
    if (test_errs == 0) begin
      tests_ok++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", num, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    int dl_cols [4];
    set_tile(0, 0);
    in_flit = '0;
    in_valid = '0;
    out_ready = '1;
    rand_ready = 1'b0;
    occ = '{0, 0};
    owed = '{default: -1};
    head_slot = '{-1, -1};
    seq = '{15'd0, 15'd0};
    {test_errs, tests_ok, tests_bad, cycles} = '0;
    void'($urandom(98));
    dl_cols = '{BASE + RING / 2 - 2, BASE + RING / 2, BASE, BASE + 3};
    @(posedge arst_n);
    @(posedge clk);
    #2;

    @(negedge clk);
    for (int s = 0; s < HT_NUM_VC_OUT; s++) begin
      check_bit($sformatf("out_valid_o[%0d]", s), 1'b0, out_valid[s]);
    end
    check_bit("in_ready_o[0]", 1'b1, in_ready[0]);
    check_bit("in_ready_o[1]", 1'b1, in_ready[1]);
    @(posedge clk);
    #2;
    finish_test(1, "reset state");

    for (int r = 0; r < 5; r++) begin
      set_tile($urandom_range(0, RING - 1), $urandom_range(0, 7));
      run_lanes(2, 10, 10);
    end
    finish_test(2, "local and vertical");

    for (int r = 0; r < 5; r++) begin
      set_tile($urandom_range(0, RING - 1), $urandom_range(0, 7));
      run_lanes(3, 20, 20);
    end
    finish_test(3, "horizontal and tie-break");

    // two dateline tiles, then an ordinary even and an odd column
    for (int r = 0; r < 4; r++) begin
      set_tile(dl_cols[r], $urandom_range(0, 7));
      run_lanes(4, 20, 0);
    end
    finish_test(4, "dateline promotion");

    set_tile(3, 2);
    rand_ready = 1'b1;
    fork
      send_lane(0, 60, 5);
      send_lane(1, 60, 5);
    join
    rand_ready = 1'b0;
    run_lanes(5, 0, 0);
    finish_test(5, "contention and back-pressure");

    $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim/ht_clk_gen.sv
`timescale 1ns/1ps

module ht_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release shortly after an edge, clear of the flops
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

//--- logic/ht_input_port.sv
`timescale 1ns/1ps

`include "ht_router_params.svh"

module ht_input_port
  import ht_router_pkg::*;
#(
  parameter ht_dir_e FROM_DIR = W
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [`HT_X_CORD_WIDTH-1:0]  my_x_i,
  input  logic [`HT_Y_CORD_WIDTH-1:0]  my_y_i,
  input  ht_flit_t [1:0]               in_flit_i,
  input  logic [1:0]                   in_valid_i,
  output logic [1:0]                   in_ready_o,
  output ht_flit_t [HT_NUM_VC_OUT-1:0] out_flit_o,
  output logic [HT_NUM_VC_OUT-1:0]     out_valid_o,
  input  logic [HT_NUM_VC_OUT-1:0]     out_ready_i
);

  ht_lane_req_t [1:0] lane_req;
  logic [1:0]         lane_deq;

  // one lane per incoming vc
  for (genvar v = 0; v < 2; v++) begin : g_lane
    ht_vc_lane #(
      .VC_ID    (v),
      .FROM_DIR (FROM_DIR)
    ) u_lane (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .my_x_i     (my_x_i),
      .my_y_i     (my_y_i),
      .in_flit_i  (in_flit_i[v]),
      .in_valid_i (in_valid_i[v]),
      .in_ready_o (in_ready_o[v]),
      .req_o      (lane_req[v]),
      .deq_i      (lane_deq[v])
    );
  end

  ht_output_alloc u_alloc (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .lane_req_i  (lane_req),
    .deq_o       (lane_deq),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

//--- logic/ht_output_alloc.sv
`timescale 1ns/1ps

`include "ht_router_params.svh"

module ht_output_alloc
  import ht_router_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  ht_lane_req_t [1:0]                  lane_req_i,
  output logic [1:0]                          deq_o,
  output ht_flit_t [HT_NUM_VC_OUT-1:0]        out_flit_o,
  output logic [HT_NUM_VC_OUT-1:0]            out_valid_o,
  input  logic [HT_NUM_VC_OUT-1:0]            out_ready_i
);

  logic [HT_NUM_VC_OUT-1:0] req0;
  logic [HT_NUM_VC_OUT-1:0] req1;
  logic [HT_NUM_VC_OUT-1:0] both;
  logic [HT_NUM_VC_OUT-1:0] grant1;
  logic [HT_NUM_VC_OUT-1:0] fire;
  // per slot, 0 favours lane 0
  logic [HT_NUM_VC_OUT-1:0] rr_ptr;

  // which lanes want each slot
  always_comb begin
    req0 = lane_req_i[0].vc_sel & {HT_NUM_VC_OUT{lane_req_i[0].valid}};
    req1 = lane_req_i[1].vc_sel & {HT_NUM_VC_OUT{lane_req_i[1].valid}};
    both = req0 & req1;
  end

  // lane 1 wins when alone or when the pointer names it
  always_comb begin
    for (int s = 0; s < HT_NUM_VC_OUT; s++) begin
      grant1[s] = req1[s] && (!req0[s] || rr_ptr[s]);
    end
  end

  // drive each slot from its winner
  always_comb begin
    for (int s = 0; s < HT_NUM_VC_OUT; s++) begin
      out_valid_o[s] = req0[s] || req1[s];
      out_flit_o[s]  = grant1[s] ? lane_req_i[1].flit : lane_req_i[0].flit;
    end
  end

  assign fire = out_valid_o & out_ready_i;

  // each lane targets one slot, so at most one bit of each term is set
  always_comb begin
    deq_o[0] = |(fire & ~grant1);
    deq_o[1] = |(fire & grant1);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr <= '0;
    end else begin
      for (int s = 0; s < HT_NUM_VC_OUT; s++) begin
        if (fire[s] && both[s]) begin
          // served lane steps aside for the other
          rr_ptr[s] <= !grant1[s];
        end else if (out_valid_o[s] && !out_ready_i[s]) begin
          // stalled winner keeps the slot so the offered flit stays stable
          rr_ptr[s] <= grant1[s];
        end
      end
    end
  end

endmodule

//--- logic/ht_vc_lane.sv
`timescale 1ns/1ps

`include "ht_router_params.svh"

module ht_vc_lane
  import ht_router_pkg::*;
#(
  parameter int      VC_ID    = 0,
  parameter ht_dir_e FROM_DIR = W
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic [`HT_X_CORD_WIDTH-1:0] my_x_i,
  input  logic [`HT_Y_CORD_WIDTH-1:0] my_y_i,
  input  ht_flit_t                    in_flit_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  output ht_lane_req_t                req_o,
  input  logic                        deq_i
);

  localparam int DEPTH = `HT_FIFO_DEPTH;
  localparam int PW = $clog2(DEPTH);

  ht_flit_t                 mem [DEPTH];
  logic [PW-1:0]            wr_ptr;
  logic [PW-1:0]            rd_ptr;
  logic [PW:0]              count;
  logic                     not_empty;
  logic                     wr_en;
  logic                     rd_en;
  ht_flit_t                 head;
  logic [HT_NUM_VC_OUT-1:0] head_sel;

  assign not_empty  = (count != '0);
  assign in_ready_o = (count != (PW + 1)'(DEPTH));
  assign wr_en      = in_valid_i && in_ready_o;
  // pop only a flit that is actually there
  assign rd_en      = deq_i && not_empty;
  assign head       = mem[rd_ptr];

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // flit storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  // route of the head flit
  ht_route_decode #(
    .VC_ID    (VC_ID),
    .FROM_DIR (FROM_DIR)
  ) u_decode (
    .dest_x_i (head.dest_x),
    .dest_y_i (head.dest_y),
    .my_x_i   (my_x_i),
    .my_y_i   (my_y_i),
    .vc_sel_o (head_sel)
  );

  always_comb begin
    req_o.valid  = not_empty;
    req_o.flit   = head;
    req_o.vc_sel = head_sel;
  end

endmodule

//--- logic/ht_route_decode.sv
`timescale 1ns/1ps

`include "ht_router_params.svh"

module ht_route_decode
  import ht_router_pkg::*;
#(
  parameter int      VC_ID    = 0,
  parameter ht_dir_e FROM_DIR = W
) (
  input  logic [`HT_X_CORD_WIDTH-1:0] dest_x_i,
  input  logic [`HT_Y_CORD_WIDTH-1:0] dest_y_i,
  input  logic [`HT_X_CORD_WIDTH-1:0] my_x_i,
  input  logic [`HT_Y_CORD_WIDTH-1:0] my_y_i,
  output logic [HT_NUM_VC_OUT-1:0]    vc_sel_o
);

  localparam int XW = `HT_X_CORD_WIDTH;
  localparam int RING = `HT_NUM_TILES_X;
  // one spare bit so the wrapped sum cannot overflow
  localparam int DW = XW + 1;
  localparam bit XY_ORDER = (`HT_XY_ORDER != 0);

  // base offsets where the ring crosses its dateline
  localparam logic [XW-1:0] DATELINE_E = XW'(RING / 2 - 2);
  localparam logic [XW-1:0] DATELINE_W = XW'(RING / 2);

  logic [XW-1:0] my_base_x;
  logic [XW-1:0] my_ring_x;
  logic [XW-1:0] dest_ring_x;
  logic [DW-1:0] cw_dist;
  logic [DW-1:0] ccw_dist;
  logic          x_eq;
  logic          y_eq;
  logic          y_gt;
  logic          go_vert;
  logic          go_cw;
  logic          go_east;
  logic          vc_bit;
  ht_vc_out_e    out_sel;

  // logical position of a physical column on the folded ring
  function automatic logic [XW-1:0] ring_pos(input logic [XW-1:0] col);
    logic [XW-1:0] base;
    base = col - XW'(`HT_BASE_X_CORD);
    if (col[0]) begin
      // odd columns run back along the fold
      return XW'(RING - 1) - (base >> 1);
    end
    return base >> 1;
  endfunction

  assign my_base_x   = my_x_i - XW'(`HT_BASE_X_CORD);
  assign my_ring_x   = ring_pos(my_x_i);
  assign dest_ring_x = ring_pos(dest_x_i);

  assign x_eq = (dest_x_i == my_x_i);
  assign y_eq = (dest_y_i == my_y_i);
  assign y_gt = (dest_y_i > my_y_i);

  // ring distances both ways round
  always_comb begin
    cw_dist  = (DW'(dest_ring_x) + DW'(RING) - DW'(my_ring_x)) % DW'(RING);
    ccw_dist = (DW'(RING) - cw_dist) % DW'(RING);
  end

  // vertical hop needed now under the chosen order
  always_comb begin
    if (XY_ORDER) begin
      go_vert = x_eq && !y_eq;
    end else begin
      go_vert = !y_eq;
    end
  end

  // shorter way wins, ring parity settles a tie
  always_comb begin
    if (cw_dist < ccw_dist) begin
      go_cw = 1'b1;
    end else if (cw_dist > ccw_dist) begin
      go_cw = 1'b0;
    end else begin
      go_cw = !my_ring_x[0];
    end
    // clockwise leaves an even column eastward, an odd one westward
    go_east = my_x_i[0] ? !go_cw : go_cw;
  end

  // vc for a horizontal hop
  always_comb begin
    if (my_x_i[0]) begin
      vc_bit = 1'(VC_ID);
    end else if (FROM_DIR == P) begin
      // injected traffic starts on vc 0
      vc_bit = 1'b0;
    end else if (go_east && (my_base_x == DATELINE_E)) begin
      vc_bit = 1'b1;
    end else if (!go_east && (my_base_x == DATELINE_W)) begin
      vc_bit = 1'b1;
    end else begin
      vc_bit = 1'(VC_ID);
    end
  end

  // pick the output slot
  always_comb begin
    if (x_eq && y_eq) begin
      out_sel = VC_P;
    end else if (go_vert) begin
      out_sel = y_gt ? VC_S : VC_N;
    end else if (go_east) begin
      out_sel = vc_bit ? VC_E1 : VC_E0;
    end else begin
      out_sel = vc_bit ? VC_W1 : VC_W0;
    end
  end

  always_comb begin
    vc_sel_o          = '0;
    vc_sel_o[out_sel] = 1'b1;
  end

endmodule

//--- logic/ht_router_pkg.sv
`include "ht_router_params.svh"

package ht_router_pkg;

  // seven vc output slots of the port
  localparam int HT_NUM_VC_OUT = 7;

  // router side a flit arrives from
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } ht_dir_e;

  // bit positions in the one-hot route and the output arrays
  typedef enum logic [2:0] {
    VC_P  = 3'd0,
    VC_W0 = 3'd1,
    VC_W1 = 3'd2,
    VC_E0 = 3'd3,
    VC_E1 = 3'd4,
    VC_N  = 3'd5,
    VC_S  = 3'd6
  } ht_vc_out_e;

  // single flit packet
  typedef struct packed {
    logic [`HT_X_CORD_WIDTH-1:0]  dest_x;
    logic [`HT_Y_CORD_WIDTH-1:0]  dest_y;
    logic [`HT_PAYLOAD_WIDTH-1:0] payload;
  } ht_flit_t;

  // head of a lane plus its decoded route
  typedef struct packed {
    logic                     valid;
    ht_flit_t                 flit;
    logic [HT_NUM_VC_OUT-1:0] vc_sel;
  } ht_lane_req_t;

endpackage

//--- include/ht_router_params.svh
`ifndef HT_ROUTER_PARAMS_SVH
`define HT_ROUTER_PARAMS_SVH

// tile coordinate widths
`define HT_X_CORD_WIDTH 4
`define HT_Y_CORD_WIDTH 3

// tiles in the folded x ring
`define HT_NUM_TILES_X 8

// physical column of the first ring tile
`define HT_BASE_X_CORD 0

// flit payload bits
`define HT_PAYLOAD_WIDTH 16

// lane fifo entries, power of two
`define HT_FIFO_DEPTH 4

// 1 = x then y, 0 = y then x
`define HT_XY_ORDER 1

`endif
